// ==== include/vcache_macros.svh ====
`ifndef VCACHE_MACROS_SVH
`define VCACHE_MACROS_SVH

// cache datapath and bus widths
`define VC_DATA_W 32
`define VC_ADDR_W 8

// cache geometry
`define VC_LINES 4
`define VC_MEM_WORDS 16

// fixed stall per line fill
`define VC_MISS_CYCLES 4

`define VC_STAT_W 16

`endif

// ==== hw/vcache_pkg.sv ====
`default_nettype none

`include "vcache_macros.svh"

package vcache_pkg;

  localparam int VC_SEL_W  = `VC_DATA_W / 8;
  localparam int VC_LANE_W = $clog2(VC_SEL_W);
  localparam int VC_IDX_W  = $clog2(`VC_MEM_WORDS);   // word index into backing store
  localparam int VC_LINE_W = $clog2(`VC_LINES);
  localparam int VC_TAG_W  = VC_IDX_W - VC_LINE_W;

  typedef enum logic [2:0] {
    OP_LD,     // load, zero extended
    OP_LDS,    // load, sign extended
    OP_ST,     // byte-masked store
    OP_AINV,   // address invalidate
    OP_TAGLV   // tag load valid
  } vc_op_e;

  typedef struct packed {
    vc_op_e                 op;
    logic [VC_IDX_W-1:0]    idx;
    logic [VC_SEL_W-1:0]    sel;
    logic [`VC_DATA_W-1:0]  wdata;
  } vc_req_s;

  typedef struct packed {
    vc_req_s                req;
    logic                   is_word;
    logic                   is_half;
    logic                   is_byte;
    logic [VC_LANE_W-1:0]   lane;    // byte offset of the access
  } vc_dec_s;

  typedef struct packed {
    vc_dec_s                dec;
    logic [`VC_DATA_W-1:0]  word;    // raw line word or tag/valid word
    logic                   miss;
  } vc_rsp_s;

endpackage

`default_nettype wire

// ==== hw/vcache_stat_pkg.sv ====
`default_nettype none

package vcache_stat_pkg;

  localparam int ST_NUM = 14;

  typedef enum logic [3:0] {
    ST_LD,
    ST_LD_W,
    ST_LD_H,
    ST_LD_B,
    ST_ST,
    ST_ST_W,
    ST_ST_H,
    ST_ST_B,
    ST_AINV,
    ST_TAGLV,
    ST_MISS_LD,
    ST_MISS_ST,
    ST_MISS_CYC,   // cycles with the miss handler busy
    ST_IDLE_CYC    // cycles with no event and no miss
  } stat_id_e;

  // one completed operation, sent with the bus ack
  typedef struct packed {
    logic                 done;
    vcache_pkg::vc_op_e   op;
    logic                 is_word;
    logic                 is_half;
    logic                 is_byte;
    logic                 miss;
  } vc_event_s;

endpackage

`default_nettype wire

// ==== hw/vcache_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcache_macros.svh"

module vcache_decode (
  input  wire logic                       clk_i,
  input  wire logic                       reset_i,
  input  wire logic                       wb_cyc_i,
  input  wire logic                       wb_stb_i,
  input  wire logic                       wb_we_i,
  input  wire logic [`VC_ADDR_W-1:0]      wb_adr_i,
  input  wire logic [`VC_DATA_W/8-1:0]    wb_sel_i,
  input  wire logic [`VC_DATA_W-1:0]      wb_dat_i,
  input  wire logic                       done_i,
  output vcache_pkg::vc_dec_s             dec_o,
  output logic                            dec_v_o
);
  import vcache_pkg::*;

  logic    busy_r;
  logic    accept;
  vc_dec_s dec_n;
  vc_dec_s dec_r;

  assign accept = wb_cyc_i & wb_stb_i & ~busy_r;   // one transaction at a time

  always_comb begin
    dec_n = '0;
    dec_n.req.idx   = wb_adr_i[VC_IDX_W-1:0];
    dec_n.req.sel   = wb_sel_i;
    dec_n.req.wdata = wb_dat_i;
    case (wb_adr_i[`VC_ADDR_W-1 -: 2])   // region bits
      2'b00:   dec_n.req.op = wb_we_i ? OP_ST : OP_LD;
      2'b01:   dec_n.req.op = OP_LDS;
      2'b10:   dec_n.req.op = OP_AINV;
      default: dec_n.req.op = OP_TAGLV;
    endcase
    case (wb_sel_i)
      4'b1111: dec_n.is_word = 1'b1;
      4'b0011: dec_n.is_half = 1'b1;
      4'b1100: begin
        dec_n.is_half = 1'b1;
        dec_n.lane    = 2'd2;
      end
      4'b0001: dec_n.is_byte = 1'b1;
      4'b0010: begin
        dec_n.is_byte = 1'b1;
        dec_n.lane    = 2'd1;
      end
      4'b0100: begin
        dec_n.is_byte = 1'b1;
        dec_n.lane    = 2'd2;
      end
      4'b1000: begin
        dec_n.is_byte = 1'b1;
        dec_n.lane    = 2'd3;
      end
      default: dec_n.lane = '0;   // odd masks count as no size
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r  <= 1'b0;
      dec_v_o <= 1'b0;
    end else begin
      dec_v_o <= accept;
      if (accept) begin
        busy_r <= 1'b1;
      end else if (done_i) begin
        busy_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_r <= dec_n;
    end
  end

  assign dec_o = dec_r;

endmodule

`default_nettype wire

// ==== hw/vcache_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcache_macros.svh"

module vcache_execute (
  input  wire logic             clk_i,
  input  wire logic             reset_i,
  input  vcache_pkg::vc_dec_s   dec_i,
  input  wire logic             dec_v_i,
  output vcache_pkg::vc_rsp_s   rsp_o,
  output logic                  rsp_v_o,
  output logic                  miss_busy_o
);
  import vcache_pkg::*;

  localparam int CNT_W = $clog2(`VC_MISS_CYCLES + 1);

  typedef enum logic [1:0] {IDLE, FILL, DONE} state_e;

  state_e                 state_r;
  logic [CNT_W-1:0]       cnt_r;
  logic [`VC_LINES-1:0]   valid_r;
  logic [VC_TAG_W-1:0]    tag_r  [`VC_LINES];
  logic [`VC_DATA_W-1:0]  data_r [`VC_LINES];
  logic [`VC_DATA_W-1:0]  mem_r  [`VC_MEM_WORDS];
  vc_dec_s                hold_r;
  vc_rsp_s                rsp_r;

  vc_dec_s                cur;
  logic [VC_LINE_W-1:0]   line;
  logic [VC_TAG_W-1:0]    tag;
  logic                   is_mem;
  logic                   hit;
  logic                   filling;
  logic                   fin;
  logic [`VC_DATA_W-1:0]  base_w;
  logic [`VC_DATA_W-1:0]  merged;
  logic [`VC_DATA_W-1:0]  rsp_word;

  function automatic logic [`VC_DATA_W-1:0] merge_bytes(
    input logic [`VC_DATA_W-1:0] old_w,
    input logic [`VC_DATA_W-1:0] new_w,
    input logic [VC_SEL_W-1:0]   sel
  );
    logic [`VC_DATA_W-1:0] res;
    res = old_w;
    for (int i = 0; i < VC_SEL_W; i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign filling = (state_r == FILL);
  assign cur     = filling ? hold_r : dec_i;   // held request while the fill runs
  assign line    = cur.req.idx[VC_LINE_W-1:0];
  assign tag     = cur.req.idx[VC_IDX_W-1:VC_LINE_W];
  assign is_mem  = cur.req.op inside {OP_LD, OP_LDS, OP_ST};
  assign hit     = valid_r[line] & (tag_r[line] == tag);
  assign base_w  = filling ? mem_r[cur.req.idx] : data_r[line];
  assign merged  = merge_bytes(base_w, cur.req.wdata, cur.req.sel);

  // request completes on this edge
  assign fin = ((state_r == IDLE) & dec_v_i & ~(is_mem & ~hit))
             | (filling & (cnt_r == '0));

  always_comb begin
    case (cur.req.op)
      OP_ST:    rsp_word = merged;
      OP_TAGLV: rsp_word = {{(`VC_DATA_W-VC_TAG_W-1){1'b0}}, valid_r[line], tag_r[line]};
      default:  rsp_word = base_w;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= IDLE;
      cnt_r   <= '0;
      valid_r <= '0;
      for (int i = 0; i < `VC_LINES; i++) begin
        tag_r[i] <= '0;
      end
      for (int i = 0; i < `VC_MEM_WORDS; i++) begin
        mem_r[i] <= '0;
      end
    end else begin
      case (state_r)
        IDLE: begin
          if (dec_v_i && is_mem && !hit) begin
            state_r <= FILL;
            cnt_r   <= CNT_W'(`VC_MISS_CYCLES - 1);
          end else if (dec_v_i) begin
            state_r <= DONE;
          end
        end
        FILL: begin
          if (cnt_r == '0) begin
            state_r <= DONE;
          end else begin
            cnt_r <= cnt_r - 1'b1;
          end
        end
        default: state_r <= IDLE;
      endcase
      if (fin && is_mem) begin
        valid_r[line] <= 1'b1;   // write-allocate
        tag_r[line]   <= tag;
      end
      if (fin && cur.req.op == OP_AINV) begin
        valid_r[line] <= 1'b0;
      end
      if (fin && cur.req.op == OP_ST) begin
        mem_r[cur.req.idx] <= merged;   // write-through
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == IDLE && dec_v_i) begin
      hold_r <= dec_i;
    end
    if (fin && is_mem) begin
      data_r[line] <= (cur.req.op == OP_ST) ? merged : base_w;
    end
    if (fin) begin
      rsp_r.dec  <= cur;
      rsp_r.word <= rsp_word;
      rsp_r.miss <= filling;
    end
  end

  assign rsp_o       = rsp_r;
  assign rsp_v_o     = (state_r == DONE);
  assign miss_busy_o = filling;

endmodule

`default_nettype wire

// ==== hw/vcache_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcache_macros.svh"

module vcache_result (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  vcache_pkg::vc_rsp_s         rsp_i,
  input  wire logic                   rsp_v_i,
  output logic                        wb_ack_o,
  output logic [`VC_DATA_W-1:0]       wb_dat_o,
  output logic                        done_o,
  output vcache_stat_pkg::vc_event_s  event_o
);
  import vcache_pkg::*;
  import vcache_stat_pkg::*;

  logic [`VC_DATA_W-1:0] shifted;
  logic [`VC_DATA_W-1:0] ld_word;
  logic [`VC_DATA_W-1:0] rdata;
  logic                  sx;

  always_comb begin
    shifted = rsp_i.word >> {rsp_i.dec.lane, 3'b000};   // lane down to bit 0
    sx      = (rsp_i.dec.req.op == OP_LDS);
    if (rsp_i.dec.is_byte) begin
      ld_word = {{(`VC_DATA_W-8){sx & shifted[7]}}, shifted[7:0]};
    end else if (rsp_i.dec.is_half) begin
      ld_word = {{(`VC_DATA_W-16){sx & shifted[15]}}, shifted[15:0]};
    end else begin
      ld_word = shifted;
    end
    case (rsp_i.dec.req.op)
      OP_LD, OP_LDS: rdata = ld_word;
      OP_TAGLV:      rdata = rsp_i.word;
      default:       rdata = '0;   // stores and invalidate
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
      event_o  <= '0;
    end else begin
      wb_ack_o        <= rsp_v_i;
      event_o.done    <= rsp_v_i;
      event_o.op      <= rsp_i.dec.req.op;
      event_o.is_word <= rsp_i.dec.is_word;
      event_o.is_half <= rsp_i.dec.is_half;
      event_o.is_byte <= rsp_i.dec.is_byte;
      event_o.miss    <= rsp_i.miss;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_v_i) begin
      wb_dat_o <= rdata;
    end
  end

  assign done_o = wb_ack_o;

endmodule

`default_nettype wire

// ==== hw/vcache_profiler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcache_macros.svh"

module vcache_profiler (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  vcache_stat_pkg::vc_event_s  event_i,
  input  wire logic                   miss_busy_i,
  input  vcache_stat_pkg::stat_id_e   stat_sel_i,
  input  wire logic                   stat_clr_i,
  output logic [`VC_STAT_W-1:0]       stat_o
);
  import vcache_pkg::*;
  import vcache_stat_pkg::*;

  logic [`VC_STAT_W-1:0] cnt_r [ST_NUM];
  logic [ST_NUM-1:0]     inc;
  logic                  ev_ld;
  logic                  ev_st;

  assign ev_ld = event_i.done & (event_i.op inside {OP_LD, OP_LDS});   // both load kinds
  assign ev_st = event_i.done & (event_i.op == OP_ST);

  always_comb begin
    inc              = '0;
    inc[ST_LD]       = ev_ld;
    inc[ST_LD_W]     = ev_ld & event_i.is_word;
    inc[ST_LD_H]     = ev_ld & event_i.is_half;
    inc[ST_LD_B]     = ev_ld & event_i.is_byte;
    inc[ST_ST]       = ev_st;
    inc[ST_ST_W]     = ev_st & event_i.is_word;
    inc[ST_ST_H]     = ev_st & event_i.is_half;
    inc[ST_ST_B]     = ev_st & event_i.is_byte;
    inc[ST_AINV]     = event_i.done & (event_i.op == OP_AINV);
    inc[ST_TAGLV]    = event_i.done & (event_i.op == OP_TAGLV);
    inc[ST_MISS_LD]  = ev_ld & event_i.miss;
    inc[ST_MISS_ST]  = ev_st & event_i.miss;
    inc[ST_MISS_CYC] = miss_busy_i;
    inc[ST_IDLE_CYC] = ~event_i.done & ~miss_busy_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || stat_clr_i) begin
      for (int i = 0; i < ST_NUM; i++) begin
        cnt_r[i] <= '0;
      end
    end else begin
      for (int i = 0; i < ST_NUM; i++) begin
        if (inc[i] && cnt_r[i] != '1) begin   // hold at max
          cnt_r[i] <= cnt_r[i] + 1'b1;
        end
      end
    end
  end

  // unused selector codes read as zero
  assign stat_o = (int'(stat_sel_i) < ST_NUM) ? cnt_r[stat_sel_i] : '0;

endmodule

`default_nettype wire

// ==== hw/vcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcache_macros.svh"

module vcache_top (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  input  wire logic                     wb_cyc_i,
  input  wire logic                     wb_stb_i,
  input  wire logic                     wb_we_i,
  input  wire logic [`VC_ADDR_W-1:0]    wb_adr_i,
  input  wire logic [`VC_DATA_W/8-1:0]  wb_sel_i,
  input  wire logic [`VC_DATA_W-1:0]    wb_dat_i,
  output logic                          wb_ack_o,
  output logic [`VC_DATA_W-1:0]         wb_dat_o,
  input  vcache_stat_pkg::stat_id_e     stat_sel_i,
  input  wire logic                     stat_clr_i,
  output logic [`VC_STAT_W-1:0]         stat_o,
  output logic                          stat_miss_o
);
  import vcache_pkg::*;
  import vcache_stat_pkg::*;

  vc_dec_s   dec;
  logic      dec_v;
  vc_rsp_s   rsp;
  logic      rsp_v;
  logic      miss_busy;
  logic      done;
  vc_event_s ev;

  vcache_decode i_decode (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_i (wb_dat_i),
    .done_i   (done),
    .dec_o    (dec),
    .dec_v_o  (dec_v)
  );

  vcache_execute i_execute (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dec_i       (dec),
    .dec_v_i     (dec_v),
    .rsp_o       (rsp),
    .rsp_v_o     (rsp_v),
    .miss_busy_o (miss_busy)
  );

  vcache_result i_result (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .rsp_i    (rsp),
    .rsp_v_i  (rsp_v),
    .wb_ack_o (wb_ack_o),
    .wb_dat_o (wb_dat_o),
    .done_o   (done),
    .event_o  (ev)
  );

  vcache_profiler i_profiler (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .event_i     (ev),
    .miss_busy_i (miss_busy),
    .stat_sel_i  (stat_sel_i),
    .stat_clr_i  (stat_clr_i),
    .stat_o      (stat_o)
  );

  assign stat_miss_o = miss_busy;

endmodule

`default_nettype wire

// ==== verif/vcache_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcache_macros.svh"

module vcache_properties (
  input wire logic clk_i,
  input wire logic reset_i,
  input wire logic wb_cyc_i,
  input wire logic wb_stb_i,
  input wire logic wb_ack_o
);
  localparam int MAX_WAIT = 3 + `VC_MISS_CYCLES;

  int wait_cnt;   // cycles of an open strobe with no ack yet

  always_ff @(posedge clk_i) begin
    if (reset_i || !(wb_cyc_i && wb_stb_i) || wb_ack_o) begin
      wait_cnt <= 0;
    end else begin
      wait_cnt <= wait_cnt + 1;
    end
  end

  ack_single: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o high for two cycles in a row");

  ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
    else $error("wb_ack_o without wb_cyc_i and wb_stb_i");

  ack_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    wait_cnt <= MAX_WAIT)
    else $error("no wb_ack_o within %0d cycles of a strobe", MAX_WAIT);

endmodule

bind vcache_top vcache_properties i_props (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_o (wb_ack_o)
);

`default_nettype wire

// ==== verif/vcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vcache_macros.svh"

module vcache_tb;
  import vcache_stat_pkg::*;

  localparam int HIT_CYCLES  = 3;
  localparam int MISS_CYCLES = 3 + `VC_MISS_CYCLES;
  localparam int ACK_TIMEOUT = 4 * MISS_CYCLES;

  typedef struct {
    string      name;
    logic [1:0] region;   // adr bits 7:6
    logic [3:0] idx;
    logic       we;
    logic [3:0] sel;
    logic       neg;      // sets the top bit of every write byte
  } entry_t;

  logic                         clk_i;
  logic                         reset_i;
  logic                         wb_cyc_i;
  logic                         wb_stb_i;
  logic                         wb_we_i;
  logic [`VC_ADDR_W-1:0]        wb_adr_i;
  logic [`VC_DATA_W/8-1:0]      wb_sel_i;
  logic [`VC_DATA_W-1:0]        wb_dat_i;
  logic                         wb_ack_o;
  logic [`VC_DATA_W-1:0]        wb_dat_o;
  stat_id_e                     stat_sel;
  logic                         stat_clr_i;
  logic [`VC_STAT_W-1:0]        stat_o;
  logic                         stat_miss_o;

  entry_t                       stim_q [$];
  logic [31:0]                  m_mem   [`VC_MEM_WORDS];   // reference backing store
  logic                         m_valid [`VC_LINES];
  logic [1:0]                   m_tag   [`VC_LINES];
  logic [`VC_STAT_W-1:0]        tally   [ST_NUM];
  logic [31:0]                  lcg_state;
  int                           errors;
  int                           checks;

  vcache_top i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_o    (wb_ack_o),
    .wb_dat_o    (wb_dat_o),
    .stat_sel_i  (stat_sel),
    .stat_clr_i  (stat_clr_i),
    .stat_o      (stat_o),
    .stat_miss_o (stat_miss_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old_w, input logic [31:0] new_w,
                                             input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // lowest selected byte moved to bit 0, then extended to the access size
  function automatic logic [31:0] load_value(input logic [31:0] word, input logic [3:0] sel,
                                             input logic sx);
    logic [31:0] shifted;
    int          lane;
    int          size;
    lane = 0;
    for (int i = 3; i >= 0; i--) begin
      if (sel[i]) begin
        lane = i;
      end
    end
    size = $countones(sel);
    shifted = word >> (8 * lane);
    if (size == 1) begin
      return {{24{sx & shifted[7]}}, shifted[7:0]};
    end else if (size == 2) begin
      return {{16{sx & shifted[15]}}, shifted[15:0]};
    end
    return shifted;
  endfunction

  task automatic bump(input int id);
    tally[id] = tally[id] + 16'd1;
  endtask

  task automatic add_entry(input string name, input logic [1:0] region, input logic [3:0] idx,
                           input logic we, input logic [3:0] sel, input logic neg);
    entry_t e;
    e.name   = name;
    e.region = region;
    e.idx    = idx;
    e.we     = we;
    e.sel    = sel;
    e.neg    = neg;
    stim_q.push_back(e);
  endtask

  task automatic read_stat(input int id, output logic [`VC_STAT_W-1:0] val);
    @(negedge clk_i);
    stat_sel = stat_id_e'(id);
    #2;
    val = stat_o;
  endtask

  task automatic check_stats(input string phase, input int num, input logic zero);
    logic [`VC_STAT_W-1:0] val;
    logic [`VC_STAT_W-1:0] exp_cnt;
    stat_id_e              id;
    for (int i = 0; i < num; i++) begin
      read_stat(i, val);
      id = stat_id_e'(i);
      exp_cnt = zero ? '0 : tally[i];
      checks++;
      if (val !== exp_cnt) begin
        errors++;
        $display("** Error %s %s: expected %0d, actual %0d", phase, id.name(), exp_cnt, val);
      end
    end
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic [1:0]  line;
    logic [1:0]  tag;
    logic        is_ld;
    logic        is_st;
    logic        miss;
    int          cycles;
    int          exp_cycles;
    int          busy_cycles;
    int          exp_busy;
    int          base;
    wdata = lcg_next();
    wdata = e.neg ? (wdata | 32'h8080_8080) : (wdata & 32'h7f7f_7f7f);
    line  = e.idx[1:0];
    tag   = e.idx[3:2];
    is_st = (e.region == 2'b00) && e.we;
    is_ld = (e.region == 2'b01) || ((e.region == 2'b00) && !e.we);
    miss  = (is_ld || is_st) && !(m_valid[line] && m_tag[line] == tag);
    exp_cycles = miss ? MISS_CYCLES : HIT_CYCLES;
    exp_busy   = miss ? `VC_MISS_CYCLES : 0;
    if (is_ld) begin
      exp_data = load_value(m_mem[e.idx], e.sel, e.region == 2'b01);
    end else if (e.region == 2'b11) begin
      exp_data = {29'b0, m_valid[line], m_tag[line]};
    end else begin
      exp_data = '0;
    end
    if (is_st) begin
      m_mem[e.idx] = merge_word(m_mem[e.idx], wdata, e.sel);   // write-through
    end
    if (is_ld || is_st) begin
      m_valid[line] = 1'b1;   // write-allocate
      m_tag[line]   = tag;
      base = is_ld ? int'(ST_LD) : int'(ST_ST);
      bump(base);
      case ($countones(e.sel))
        4: bump(base + 1);
        2: bump(base + 2);
        default: bump(base + 3);
      endcase
      if (miss) begin
        bump(is_ld ? int'(ST_MISS_LD) : int'(ST_MISS_ST));
        tally[ST_MISS_CYC] = tally[ST_MISS_CYC] + 16'(`VC_MISS_CYCLES);
      end
    end else if (e.region == 2'b10) begin
      m_valid[line] = 1'b0;
      bump(ST_AINV);
    end else begin
      bump(ST_TAGLV);
    end

    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = e.we;
    wb_adr_i = {e.region, 2'b00, e.idx};
    wb_sel_i = e.sel;
    wb_dat_i = wdata;
    cycles = 0;
    busy_cycles = 0;
    while (!wb_ack_o && cycles < ACK_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      if (stat_miss_o === 1'b1) begin
        busy_cycles++;
      end
    end
    checks++;
    if (!wb_ack_o) begin
      errors++;
      $display("%s: no ack from the DUT within %0d cycles", e.name, ACK_TIMEOUT);
    end else begin
      if (cycles != exp_cycles) begin
        errors++;
        $display("** Error %s latency: expected %0d, actual %0d", e.name, exp_cycles, cycles);
      end
      if (wb_dat_o !== exp_data) begin
        errors++;
        $display("** Error %s data: expected %h, actual %h", e.name, exp_data, wb_dat_o);
      end
      if (busy_cycles != exp_busy) begin
        errors++;
        $display("** Error %s miss busy cycles: expected %0d, actual %0d", e.name, exp_busy,
                 busy_cycles);
      end
    end
    @(negedge clk_i);   // strobe drops in the cycle after ack
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  initial begin
    lcg_state  = 32'h71c;
    errors     = 0;
    checks     = 0;
    reset_i    = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_sel_i   = '0;
    wb_dat_i   = '0;
    stat_sel   = ST_LD;
    stat_clr_i = 1'b0;
    for (int i = 0; i < `VC_MEM_WORDS; i++) begin
      m_mem[i] = '0;
    end
    for (int i = 0; i < `VC_LINES; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
    end
    for (int i = 0; i < ST_NUM; i++) begin
      tally[i] = '0;
    end

    add_entry("st_w_5",        2'b00, 4'd5,  1'b1, 4'b1111, 1'b1);   // first fill of line 1
    add_entry("ld_w_5",        2'b00, 4'd5,  1'b0, 4'b1111, 1'b0);
    add_entry("st_h_5_hi",     2'b00, 4'd5,  1'b1, 4'b1100, 1'b1);
    add_entry("st_b_5_b0",     2'b00, 4'd5,  1'b1, 4'b0001, 1'b0);
    add_entry("lds_h_5_hi",    2'b01, 4'd5,  1'b0, 4'b1100, 1'b0);
    add_entry("ld_h_5_hi",     2'b00, 4'd5,  1'b0, 4'b1100, 1'b0);
    add_entry("lds_b_5_b0",    2'b01, 4'd5,  1'b0, 4'b0001, 1'b0);
    add_entry("ld_b_5_b0",     2'b00, 4'd5,  1'b0, 4'b0001, 1'b0);
    add_entry("lds_b_5_b1",    2'b01, 4'd5,  1'b0, 4'b0010, 1'b0);
    add_entry("ld_b_5_b1",     2'b00, 4'd5,  1'b0, 4'b0010, 1'b0);
    add_entry("taglv_5",       2'b11, 4'd5,  1'b0, 4'b1111, 1'b0);
    add_entry("ainv_5",        2'b10, 4'd5,  1'b0, 4'b1111, 1'b0);
    add_entry("taglv_5_inv",   2'b11, 4'd5,  1'b0, 4'b1111, 1'b0);
    add_entry("ld_w_5_refill", 2'b00, 4'd5,  1'b0, 4'b1111, 1'b0);
    add_entry("ld_w_9_evict",  2'b00, 4'd9,  1'b0, 4'b1111, 1'b0);   // same line with a new tag
    add_entry("taglv_9",       2'b11, 4'd9,  1'b0, 4'b1111, 1'b0);
    add_entry("ld_w_5_again",  2'b00, 4'd5,  1'b0, 4'b1111, 1'b0);
    add_entry("st_b_14_b3",    2'b00, 4'd14, 1'b1, 4'b1000, 1'b1);
    add_entry("lds_w_14",      2'b01, 4'd14, 1'b0, 4'b1111, 1'b0);
    add_entry("lds_b_14_b3",   2'b01, 4'd14, 1'b0, 4'b1000, 1'b0);
    add_entry("ld_h_2_lo",     2'b00, 4'd2,  1'b0, 4'b0011, 1'b0);

    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;

    for (int i = 0; i < 5; i++) begin
      @(negedge clk_i);
      checks++;
      if (wb_ack_o !== 1'b0) begin
        errors++;
        $display("** Error reset_ack: expected 0, actual %b", wb_ack_o);
      end
    end
    check_stats("reset", int'(ST_IDLE_CYC), 1'b1);   // idle counter runs from reset

    foreach (stim_q[k]) begin
      run_entry(stim_q[k]);
    end
    repeat (2) @(negedge clk_i);
    check_stats("tally", int'(ST_IDLE_CYC), 1'b0);

    @(negedge clk_i);
    stat_clr_i = 1'b1;
    check_stats("clear", ST_NUM, 1'b1);
    stat_clr_i = 1'b0;

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hw/vcache_pkg.sv
hw/vcache_stat_pkg.sv
hw/vcache_decode.sv
hw/vcache_execute.sv
hw/vcache_result.sv
hw/vcache_profiler.sv
hw/vcache_top.sv
verif/vcache_properties.sv
verif/vcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vcache_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
